// File: verilog.f
+incdir+dv
source/arith_op_pkg.sv
source/arith_cfg_pkg.sv
source/op_decode.sv
source/comb_alu.sv
source/mult_pipe.sv
source/div_iter.sv
source/result_stage.sv
source/arith_top.sv
dv/arith_tb.sv

// File: Bender.yml
package:
  name: arith_unit

sources:
  - files:
      - source/arith_op_pkg.sv
      - source/arith_cfg_pkg.sv
      - source/op_decode.sv
      - source/comb_alu.sv
      - source/mult_pipe.sv
      - source/div_iter.sv
      - source/result_stage.sv
      - source/arith_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/arith_tb.sv

// File: dv/arith_model.svh
// Reference model and random source for the arithmetic unit testbench.
// Included inside the testbench module, which declares WIDTH and lfsr_q.
`ifndef ARITH_MODEL_SVH
`define ARITH_MODEL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// One LFSR step for each bit taken
function automatic logic [WIDTH-1:0] take_bits(input int n);
  logic [WIDTH-1:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = lfsr_step(lfsr_q);
    v = {v[WIDTH-2:0], lfsr_q[0]};
  end
  return v;
endfunction

// Expected out and remainder of one operation
function automatic void model_op(input arith_op_pkg::opcode_t op_m,
                                 input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                                 output logic [WIDTH-1:0] q, output logic [WIDTH-1:0] r);
  logic [2*WIDTH-1:0] full;
  logic [WIDTH-1:0]   msb;
  logic [WIDTH-1:0]   ua;
  logic [WIDTH-1:0]   ub;
  logic [WIDTH-1:0]   q0;
  logic [WIDTH-1:0]   t0;
  logic [WIDTH-1:0]   t1;
  logic               sa;
  logic               sb;
  msb  = {1'b1, {(WIDTH-1){1'b0}}};
  sa   = a[WIDTH-1];
  sb   = b[WIDTH-1];
  ua   = sa ? ~a + 1'b1 : a;
  ub   = sb ? ~b + 1'b1 : b;
  full = a * b;
  r    = '0;
  case (op_m)
    arith_op_pkg::OP_SUB: q = a - b;
    arith_op_pkg::OP_AND: q = a & b;
    arith_op_pkg::OP_OR:  q = a | b;
    arith_op_pkg::OP_XOR: q = a ^ b;
    arith_op_pkg::OP_SHL: q = (b >= WIDTH) ? '0 : a << b;
    arith_op_pkg::OP_SHR: q = (b >= WIDTH) ? '0 : a >> b;
    arith_op_pkg::OP_LT:  q = (a < b) ? 1 : 0;
    arith_op_pkg::OP_GT:  q = (a > b) ? 1 : 0;
    arith_op_pkg::OP_EQ:  q = (a == b) ? 1 : 0;
    // Flipping the sign bit turns a signed order into an unsigned one
    arith_op_pkg::OP_SLT: q = ((a ^ msb) < (b ^ msb)) ? 1 : 0;
    arith_op_pkg::OP_SGT: q = ((a ^ msb) > (b ^ msb)) ? 1 : 0;
    arith_op_pkg::OP_MUL: q = full[WIDTH-1:0];
    arith_op_pkg::OP_DIV: begin
      if (a == '0) begin
        q = '0;
      end else if (b == '0) begin
        q = '1;
        r = a;
      end else begin
        q = a / b;
        r = a % b;
      end
    end
    arith_op_pkg::OP_SDIV: begin
      q0 = ua / ub;
      t0 = ua % ub;
      q  = (sa ^ sb) ? ~q0 + 1'b1 : q0;
      t1 = ((sa ^ sb) && t0 != '0) ? ub - t0 : t0;
      r  = sb ? ~t1 + 1'b1 : t1;
    end
    default: q = a + b;
  endcase
endfunction

`endif

// File: dv/arith_tb.sv
`timescale 1ns/1ps
// Testbench for the integer arithmetic unit. Issues random operations over
// go/ready/done and compares every result with the model in arith_model.svh.
module arith_tb;
  localparam int WIDTH          = 32;
  localparam int RESET_CYCLES   = 5;
  localparam int TIMEOUT_CYCLES = 400 * (WIDTH + 6) + RESET_CYCLES;
  localparam int ALU_LATENCY    = 2;
  localparam int MUL_LATENCY    = arith_cfg_pkg::MULT_STAGES + 2;

  logic                  clk;
  logic                  reset;
  logic                  go;
  arith_op_pkg::opcode_t op;
  logic [WIDTH-1:0]      left;
  logic [WIDTH-1:0]      right;
  logic                  ready;
  logic                  done;
  logic [WIDTH-1:0]      out;
  logic [WIDTH-1:0]      remainder;
  logic [15:0]           lfsr_q;
  int                    cycle_count = 0;

  `include "arith_model.svh"

  arith_top #(.WIDTH(WIDTH)) dut (
    .clk(clk), .reset(reset), .go(go), .op(op), .left(left), .right(right),
    .ready(ready), .done(done), .out(out), .remainder(remainder)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [WIDTH-1:0] got,
                             input logic [WIDTH-1:0] expected);
    if (got !== expected) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // Issue one operation, wait for done and check the result.
  // With poke set, go is pulsed with junk while ready is low.
  task automatic run_op(input arith_op_pkg::opcode_t op_v, input logic [WIDTH-1:0] a,
                        input logic [WIDTH-1:0] b, input bit poke, output int latency);
    logic [WIDTH-1:0] exp_q;
    logic [WIDTH-1:0] exp_r;
    model_op(op_v, a, b, exp_q, exp_r);
    check_value("ready", ready, 1);
    go    = 1'b1;
    op    = op_v;
    left  = a;
    right = b;
    @(posedge clk);
    #1;
    go      = 1'b0;
    // The accept edge counts as edge 1
    latency = 1;
    do begin
      if (poke && !ready && take_bits(1) == 1) begin
        go    = 1'b1;
        op    = arith_op_pkg::opcode_t'(4'(take_bits(4) % 15));
        left  = take_bits(WIDTH);
        right = take_bits(WIDTH);
      end
      @(posedge clk);
      #1;
      go = 1'b0;
      latency++;
    end while (!done);
    check_value("ready", ready, 1);
    check_value("out", out, exp_q);
    check_value("remainder", remainder, exp_r);
  endtask

  initial begin
    int                    latency;
    logic [WIDTH-1:0]      a;
    logic [WIDTH-1:0]      b;
    arith_op_pkg::opcode_t op_v;
    lfsr_q = 16'd25539;
    reset  = 1'b1;
    go     = 1'b0;
    op     = arith_op_pkg::OP_ADD;
    left   = '0;
    right  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    check_value("ready", ready, 1);
    check_value("done", done, 0);
    check_value("out", out, 0);
    check_value("remainder", remainder, 0);

    // Single-cycle operations from add through sgt
    for (int i = 0; i < 150; i++) begin
      op_v = arith_op_pkg::opcode_t'(4'(take_bits(4) % 12));
      a    = take_bits(WIDTH);
      b    = take_bits(WIDTH);
      if (op_v == arith_op_pkg::OP_SHL || op_v == arith_op_pkg::OP_SHR) begin
        b = take_bits(6);
      end else if (take_bits(2) == 0) begin
        b = a;
      end
      run_op(op_v, a, b, 1'b0, latency);
      check_value("alu latency", latency, ALU_LATENCY);
    end

    for (int i = 0; i < 60; i++) begin
      a = take_bits(WIDTH);
      b = take_bits(WIDTH) >> take_bits(5);
      run_op(arith_op_pkg::OP_MUL, a, b, 1'b0, latency);
      check_value("mul latency", latency, MUL_LATENCY);
    end

    // Zero dividend, zero divisor, then random divides
    run_op(arith_op_pkg::OP_DIV, '0, take_bits(WIDTH), 1'b0, latency);
    run_op(arith_op_pkg::OP_DIV, take_bits(WIDTH), '0, 1'b0, latency);
    run_op(arith_op_pkg::OP_DIV, '0, '0, 1'b0, latency);
    for (int i = 0; i < 60; i++) begin
      a = (take_bits(3) == 0) ? '0 : take_bits(WIDTH);
      b = take_bits(WIDTH) >> take_bits(5);
      run_op(arith_op_pkg::OP_DIV, a, b, 1'b0, latency);
    end

    // Signed divides cycling through all four sign combinations
    for (int i = 0; i < 60; i++) begin
      a = take_bits(WIDTH - 1) >> take_bits(4);
      b = take_bits(WIDTH - 1) >> take_bits(5);
      if (b == '0) begin
        b = 1;
      end
      if (i[0]) begin
        a = -a;
      end
      if (i[1]) begin
        b = -b;
      end
      run_op(arith_op_pkg::OP_SDIV, a, b, 1'b0, latency);
    end

    // Junk go pulses while busy must leave the result and done alone
    for (int i = 0; i < 20; i++) begin
      case (i % 4)
        0:       op_v = arith_op_pkg::OP_MUL;
        1:       op_v = arith_op_pkg::OP_DIV;
        2:       op_v = arith_op_pkg::OP_SDIV;
        default: op_v = arith_op_pkg::OP_ADD;
      endcase
      a = take_bits(WIDTH);
      b = take_bits(WIDTH) >> take_bits(5);
      if (b == '0) begin
        b = 3;
      end
      run_op(op_v, a, b, 1'b1, latency);
      repeat (3) begin
        @(posedge clk);
        #1;
        check_value("done", done, 0);
      end
      check_value("ready", ready, 1);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: source/arith_top.sv
`timescale 1ns/1ps
// Integer arithmetic unit with a go/ready/done handshake.
// One operation in flight at a time, results held until the next done.
module arith_top #(
  parameter int WIDTH = arith_cfg_pkg::DEFAULT_WIDTH
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  go,
  input  arith_op_pkg::opcode_t op,
  input  logic [WIDTH-1:0]      left,
  input  logic [WIDTH-1:0]      right,
  output logic                  ready,
  output logic                  done,
  output logic [WIDTH-1:0]      out,
  output logic [WIDTH-1:0]      remainder
);
  arith_op_pkg::opcode_t op_q;
  arith_op_pkg::unit_t   unit_q;
  logic [WIDTH-1:0]      left_q, right_q;
  logic                  left_neg, right_neg;
  logic                  alu_start, mul_start, div_start;
  logic [WIDTH-1:0]      alu_result, product, quotient, div_remainder;
  logic                  alu_valid, mul_valid, div_valid;
  logic                  signed_div;

  assign signed_div = (op_q == arith_op_pkg::OP_SDIV);

  op_decode #(.WIDTH(WIDTH)) u_decode (
    .clk(clk), .reset(reset), .go(go), .op(op), .left(left), .right(right),
    .done(done), .ready(ready), .op_q(op_q), .unit_q(unit_q),
    .left_q(left_q), .right_q(right_q), .left_neg(left_neg), .right_neg(right_neg),
    .alu_start(alu_start), .mul_start(mul_start), .div_start(div_start)
  );

  comb_alu #(.WIDTH(WIDTH)) u_alu (
    .op(op_q), .left(left_q), .right(right_q), .start(alu_start),
    .result(alu_result), .valid(alu_valid)
  );

  mult_pipe #(.WIDTH(WIDTH)) u_mult (
    .clk(clk), .reset(reset), .start(mul_start), .left(left_q), .right(right_q),
    .product(product), .valid(mul_valid)
  );

  div_iter #(.WIDTH(WIDTH)) u_div (
    .clk(clk), .reset(reset), .start(div_start), .dividend(left_q), .divisor(right_q),
    .quotient(quotient), .remainder(div_remainder), .valid(div_valid)
  );

  result_stage #(.WIDTH(WIDTH)) u_result (
    .clk(clk), .reset(reset), .unit_q(unit_q), .signed_div(signed_div),
    .left_neg(left_neg), .right_neg(right_neg), .divisor_abs(right_q),
    .alu_result(alu_result), .alu_valid(alu_valid),
    .product(product), .mul_valid(mul_valid),
    .quotient(quotient), .div_remainder(div_remainder), .div_valid(div_valid),
    .out(out), .remainder(remainder), .done(done)
  );

endmodule

// File: source/result_stage.sv
`timescale 1ns/1ps
// Picks the finishing unit's result, restores signs for signed divide
// and registers out and remainder together with a one-cycle done.
module result_stage #(
  parameter int WIDTH = arith_cfg_pkg::DEFAULT_WIDTH
) (
  input  logic                clk,
  input  logic                reset,
  input  arith_op_pkg::unit_t unit_q,
  input  logic                signed_div,
  input  logic                left_neg,
  input  logic                right_neg,
  input  logic [WIDTH-1:0]    divisor_abs,
  input  logic [WIDTH-1:0]    alu_result,
  input  logic                alu_valid,
  input  logic [WIDTH-1:0]    product,
  input  logic                mul_valid,
  input  logic [WIDTH-1:0]    quotient,
  input  logic [WIDTH-1:0]    div_remainder,
  input  logic                div_valid,
  output logic [WIDTH-1:0]    out,
  output logic [WIDTH-1:0]    remainder,
  output logic                done
);
  typedef logic [WIDTH-1:0] word_t;

  logic  any_valid;
  logic  diff_sign;
  word_t quot_signed;
  word_t rem_t1;
  word_t rem_signed;
  word_t out_d;
  word_t rem_d;

  assign any_valid = alu_valid | mul_valid | div_valid;
  assign diff_sign = left_neg ^ right_neg;

  // Quotient truncates toward zero, remainder takes the sign of the divisor
  assign quot_signed = diff_sign ? -quotient : quotient;
  assign rem_t1      = (diff_sign && div_remainder != '0) ? divisor_abs - div_remainder
                                                          : div_remainder;
  assign rem_signed  = right_neg ? -rem_t1 : rem_t1;

  always_comb begin
    case (unit_q)
      arith_op_pkg::UNIT_MUL: begin
        out_d = product;
        rem_d = '0;
      end
      arith_op_pkg::UNIT_DIV: begin
        out_d = signed_div ? quot_signed : quotient;
        rem_d = signed_div ? rem_signed : div_remainder;
      end
      default: begin
        out_d = alu_result;
        rem_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out       <= '0;
      remainder <= '0;
      done      <= 1'b0;
    end else begin
      done <= any_valid;
      if (any_valid) begin
        out       <= out_d;
        remainder <= rem_d;
      end
    end
  end

  a_done_pulse: assert property (@(posedge clk) disable iff (reset)
    done |=> !done);

endmodule

// File: source/div_iter.sv
`timescale 1ns/1ps
// Restoring unsigned divider, one quotient bit per cycle.
// Takes WIDTH+1 edges from start, or one edge for a zero dividend.
module div_iter #(
  parameter int WIDTH = arith_cfg_pkg::DEFAULT_WIDTH
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic [WIDTH-1:0] dividend,
  input  logic [WIDTH-1:0] divisor,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder,
  output logic             valid
);
  typedef logic [WIDTH-1:0]         word_t;
  typedef logic [2*WIDTH-2:0]       wide_t;
  typedef logic [$clog2(WIDTH)-1:0] count_t;

  arith_cfg_pkg::div_state_t state;

  word_t  rem_q;
  word_t  quot_q;
  word_t  mask;
  wide_t  div_shift;
  count_t count;
  logic   fits;

  // Shifted divisor still fits into what is left of the dividend
  assign fits = div_shift <= wide_t'(rem_q);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= arith_cfg_pkg::DIV_IDLE;
    end else begin
      case (state)
        arith_cfg_pkg::DIV_IDLE: begin
          if (start && dividend == '0) begin
            state <= arith_cfg_pkg::DIV_DONE;
          end else if (start) begin
            state <= arith_cfg_pkg::DIV_RUN;
          end
        end
        arith_cfg_pkg::DIV_RUN: begin
          if (count == count_t'(WIDTH - 1)) begin
            state <= arith_cfg_pkg::DIV_DONE;
          end
        end
        default: state <= arith_cfg_pkg::DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      rem_q     <= dividend;
      quot_q    <= '0;
      div_shift <= wide_t'(divisor) << (WIDTH - 1);
      mask      <= word_t'(1) << (WIDTH - 1);
      count     <= '0;
    end else if (state == arith_cfg_pkg::DIV_RUN) begin
      if (fits) begin
        rem_q  <= rem_q - word_t'(div_shift);
        quot_q <= quot_q | mask;
      end
      div_shift <= div_shift >> 1;
      mask      <= mask >> 1;
      count     <= count + 1'b1;
    end
  end

  assign quotient  = quot_q;
  assign remainder = rem_q;
  assign valid     = (state == arith_cfg_pkg::DIV_DONE);

  a_no_overlap: assert property (@(posedge clk) disable iff (reset)
    start |-> state != arith_cfg_pkg::DIV_RUN);

endmodule

// File: source/mult_pipe.sv
`timescale 1ns/1ps
// Two-stage multiplier returning the low word of the product.
// Operands are captured on start, valid follows two edges later.
module mult_pipe #(
  parameter int WIDTH = arith_cfg_pkg::DEFAULT_WIDTH
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic [WIDTH-1:0] left,
  input  logic [WIDTH-1:0] right,
  output logic [WIDTH-1:0] product,
  output logic             valid
);
  typedef logic [WIDTH-1:0] word_t;
  localparam int STAGES = arith_cfg_pkg::MULT_STAGES;

  logic [STAGES-1:0] vld_pipe;
  word_t             left_s1;
  word_t             right_s1;

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[STAGES-2:0], start};
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      left_s1  <= left;
      right_s1 <= right;
    end
    // Low word only
    if (vld_pipe[0]) begin
      product <= left_s1 * right_s1;
    end
  end

  assign valid = vld_pipe[STAGES-1];

endmodule

// File: source/comb_alu.sv
`timescale 1ns/1ps
// Single-cycle operations: add, sub, logic, shifts and compares.
// The result is valid in the same cycle as start.
module comb_alu #(
  parameter int WIDTH = arith_cfg_pkg::DEFAULT_WIDTH
) (
  input  arith_op_pkg::opcode_t op,
  input  logic [WIDTH-1:0]      left,
  input  logic [WIDTH-1:0]      right,
  input  logic                  start,
  output logic [WIDTH-1:0]      result,
  output logic                  valid
);
  typedef logic [WIDTH-1:0] word_t;

  always_comb begin
    case (op)
      arith_op_pkg::OP_SUB: result = left - right;
      arith_op_pkg::OP_AND: result = left & right;
      arith_op_pkg::OP_OR:  result = left | right;
      arith_op_pkg::OP_XOR: result = left ^ right;
      // Full shift amount, anything of WIDTH or more clears the word
      arith_op_pkg::OP_SHL: result = left << right;
      arith_op_pkg::OP_SHR: result = left >> right;
      arith_op_pkg::OP_LT:  result = word_t'(left < right);
      arith_op_pkg::OP_GT:  result = word_t'(left > right);
      arith_op_pkg::OP_EQ:  result = word_t'(left == right);
      arith_op_pkg::OP_SLT: result = word_t'($signed(left) < $signed(right));
      arith_op_pkg::OP_SGT: result = word_t'($signed(left) > $signed(right));
      default:              result = left + right;
    endcase
  end

  assign valid = start;

endmodule

// File: source/op_decode.sv
`timescale 1ns/1ps
// Front end of the arithmetic unit. Accepts one operation on go and ready,
// registers it and fires a one-cycle start at the unit that executes it.
module op_decode #(
  parameter int WIDTH = arith_cfg_pkg::DEFAULT_WIDTH
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  go,
  input  arith_op_pkg::opcode_t op,
  input  logic [WIDTH-1:0]      left,
  input  logic [WIDTH-1:0]      right,
  input  logic                  done,
  output logic                  ready,
  output arith_op_pkg::opcode_t op_q,
  output arith_op_pkg::unit_t   unit_q,
  output logic [WIDTH-1:0]      left_q,
  output logic [WIDTH-1:0]      right_q,
  output logic                  left_neg,
  output logic                  right_neg,
  output logic                  alu_start,
  output logic                  mul_start,
  output logic                  div_start
);
  typedef logic [WIDTH-1:0] word_t;

  logic                busy;
  logic                accept;
  logic                is_sdiv;
  word_t               left_abs;
  word_t               right_abs;
  arith_op_pkg::unit_t unit_d;

  // Ready again as soon as the result is presented
  assign ready   = ~busy | done;
  assign accept  = go & ready;
  assign is_sdiv = (op == arith_op_pkg::OP_SDIV);

  assign left_abs  = left[WIDTH-1] ? -left : left;
  assign right_abs = right[WIDTH-1] ? -right : right;

  always_comb begin
    case (op)
      arith_op_pkg::OP_MUL:  unit_d = arith_op_pkg::UNIT_MUL;
      arith_op_pkg::OP_DIV,
      arith_op_pkg::OP_SDIV: unit_d = arith_op_pkg::UNIT_DIV;
      default:               unit_d = arith_op_pkg::UNIT_ALU;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      op_q      <= arith_op_pkg::OP_ADD;
      unit_q    <= arith_op_pkg::UNIT_ALU;
      alu_start <= 1'b0;
      mul_start <= 1'b0;
      div_start <= 1'b0;
    end else begin
      alu_start <= accept && (unit_d == arith_op_pkg::UNIT_ALU);
      mul_start <= accept && (unit_d == arith_op_pkg::UNIT_MUL);
      div_start <= accept && (unit_d == arith_op_pkg::UNIT_DIV);
      if (accept) begin
        busy   <= 1'b1;
        op_q   <= op;
        unit_q <= unit_d;
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  // Signed divide runs on magnitudes, signs are restored at the result stage
  always_ff @(posedge clk) begin
    if (accept) begin
      left_q    <= is_sdiv ? left_abs : left;
      right_q   <= is_sdiv ? right_abs : right;
      left_neg  <= is_sdiv & left[WIDTH-1];
      right_neg <= is_sdiv & right[WIDTH-1];
    end
  end

  a_one_start: assert property (@(posedge clk) disable iff (reset)
    $onehot0({alu_start, mul_start, div_start}));

endmodule

// File: source/arith_cfg_pkg.sv
// Sizing defaults and divider state encoding for the arithmetic unit.
package arith_cfg_pkg;

  // Default data width of every module
  localparam int DEFAULT_WIDTH = 32;

  // Registered stages in the multiplier
  localparam int MULT_STAGES = 2;

  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_RUN  = 2'd1,
    DIV_DONE = 2'd2
  } div_state_t;

endpackage

// File: source/arith_op_pkg.sv
// Operation encoding for the integer arithmetic unit.
// Shared by the decoder, the ALU, the result stage and the testbench.
package arith_op_pkg;

  // Code 4'd15 is unused and executes as an add
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SHL  = 4'd5,
    OP_SHR  = 4'd6,
    OP_LT   = 4'd7,
    OP_GT   = 4'd8,
    OP_EQ   = 4'd9,
    OP_SLT  = 4'd10,
    OP_SGT  = 4'd11,
    OP_MUL  = 4'd12,
    OP_DIV  = 4'd13,
    OP_SDIV = 4'd14
  } opcode_t;

  // Execution unit that owns an operation
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_MUL = 2'd1,
    UNIT_DIV = 2'd2
  } unit_t;

endpackage
